// File: src/dcache_pkg.sv
package dcache_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  sel_t;
    typedef logic [15:0] tag_t;
    typedef logic [5:0]  idx_t;
    typedef logic [1:0]  off_t;
    typedef logic [63:0] line_t; // Word 0 sits in bits 15:0

    typedef struct packed {
        tag_t  tag;
        line_t line;
        logic  dirty;
        logic  valid;
    } entry_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        sel_t  sel;
        logic  we;
        logic  cache_en;
    } cpu_req_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_EVICT,
        S_MERGE_WAIT,
        S_MERGE,
        S_UNCACHED
    } state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[23:8];
    endfunction

    function automatic idx_t addr_idx(addr_t a);
        return a[7:2];
    endfunction

    function automatic off_t addr_off(addr_t a);
        return a[1:0];
    endfunction

    function automatic word_t line_word(line_t l, off_t o);
        return l[{o, 4'b0000} +: 16];
    endfunction

endpackage

// File: src/dcache_ram.sv
`timescale 1ns/100ps

module dcache_ram #(
    parameter int P_DEPTH = 64
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  dcache_pkg::idx_t   i_addr,
    input  logic               i_we,
    input  dcache_pkg::entry_t i_data,
    output dcache_pkg::entry_t o_data
);

    dcache_pkg::entry_t mem [P_DEPTH];
    dcache_pkg::entry_t rd_q;
    logic [P_DEPTH-1:0] valid_q; // Kept apart so reset clears all sets in one cycle
    logic               rd_valid_q;

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_data;
        end
        rd_q <= mem[i_addr]; // Read-first on a write to the same set
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (i_we) begin
                valid_q[i_addr] <= i_data.valid;
            end
            rd_valid_q <= valid_q[i_addr];
        end
    end

    always_comb begin
        o_data       = rd_q;
        o_data.valid = rd_valid_q;
    end

endmodule

// File: src/dcache_beat_cnt.sv
`timescale 1ns/100ps

module dcache_beat_cnt (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_load,
    input  dcache_pkg::off_t i_start,
    input  logic             i_single,
    input  logic             i_active,
    input  logic             i_wb_ack,
    output dcache_pkg::off_t o_beat,
    output logic            o_xfer_end
);

    dcache_pkg::off_t beat_q;
    logic             beat_done;

    // A beat completes when cyc, stb and ack are all high
    assign beat_done = i_active & i_wb_ack;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            beat_q <= '0;
        end else if (i_load) begin
            beat_q <= i_start;
        end else if (beat_done) begin
            beat_q <= beat_q + 1'b1; // Wraps to 0 after the fourth beat
        end
    end

    assign o_beat = beat_q;

    // Single transfers end on their only beat, bursts on word offset 3
    assign o_xfer_end = beat_done & (i_single | (&beat_q));

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter dcache_pkg::addr_t P_FIRST_PAGE = 24'h000800
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  dcache_pkg::cpu_req_t i_req,
    input  logic                 i_mem_req,
    input  logic                 i_hit,
    input  logic                 i_all_dirty,
    input  logic                 i_xfer_end,
    output logic                 o_mem_ack,
    output logic                 o_mem_exception,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic                 o_cnt_load,
    output dcache_pkg::off_t     o_cnt_start,
    output logic                 o_fill_we,
    output logic                 o_merge_we,
    output logic                 o_pick_way,
    output logic                 o_evict_sel,
    output logic                 o_fill_done
);

    dcache_pkg::state_t state_q;
    logic               illegal;
    logic               start_req;
    logic               fill_end;

    assign illegal   = i_req.addr < P_FIRST_PAGE;
    assign start_req = (state_q == dcache_pkg::S_IDLE) && i_mem_req && !illegal;
    assign fill_end  = (state_q == dcache_pkg::S_FILL) && i_xfer_end;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q  <= dcache_pkg::S_IDLE;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
        end else begin
            case (state_q)
                dcache_pkg::S_IDLE: begin
                    if (start_req && i_req.cache_en) begin
                        state_q <= dcache_pkg::S_LOOKUP;
                    end else if (start_req) begin
                        state_q  <= dcache_pkg::S_UNCACHED;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= i_req.we;
                    end
                end
                dcache_pkg::S_LOOKUP: begin
                    if (i_hit) begin
                        state_q <= i_req.we ? dcache_pkg::S_MERGE : dcache_pkg::S_IDLE;
                    end else begin
                        // Write the victim back first when no clean or free way is left
                        state_q  <= i_all_dirty ? dcache_pkg::S_EVICT : dcache_pkg::S_FILL;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= i_all_dirty;
                    end
                end
                dcache_pkg::S_EVICT: begin
                    if (i_xfer_end) begin
                        state_q <= dcache_pkg::S_FILL;
                        o_wb_we <= 1'b0; // cyc stays high across the turnaround
                    end
                end
                dcache_pkg::S_FILL: begin
                    if (i_xfer_end) begin
                        state_q  <= i_req.we ? dcache_pkg::S_MERGE_WAIT : dcache_pkg::S_IDLE;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                    end
                end
                dcache_pkg::S_MERGE_WAIT: state_q <= dcache_pkg::S_MERGE; // RAM re-reads the fill
                dcache_pkg::S_MERGE:      state_q <= dcache_pkg::S_IDLE;
                dcache_pkg::S_UNCACHED: begin
                    if (i_xfer_end) begin
                        state_q  <= dcache_pkg::S_IDLE;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                    end
                end
                default: state_q <= dcache_pkg::S_IDLE;
            endcase
        end
    end

    always_comb begin
        o_cnt_load  = 1'b0;
        o_cnt_start = '0;
        case (state_q)
            dcache_pkg::S_IDLE: begin
                if (start_req && !i_req.cache_en) begin
                    o_cnt_load  = 1'b1;
                    o_cnt_start = dcache_pkg::addr_off(i_req.addr);
                end
            end
            dcache_pkg::S_LOOKUP: o_cnt_load = !i_hit;
            dcache_pkg::S_EVICT:  o_cnt_load = i_xfer_end;
            default: ;
        endcase
    end

    assign o_mem_ack = ((state_q == dcache_pkg::S_LOOKUP) && i_hit && !i_req.we)
                     | (fill_end && !i_req.we)
                     | (state_q == dcache_pkg::S_MERGE)
                     | ((state_q == dcache_pkg::S_UNCACHED) && i_xfer_end);

    assign o_mem_exception = (state_q == dcache_pkg::S_IDLE) && i_mem_req && illegal;

    assign o_fill_we   = fill_end;
    assign o_fill_done = fill_end;
    assign o_merge_we  = state_q == dcache_pkg::S_MERGE;
    assign o_pick_way  = state_q == dcache_pkg::S_LOOKUP;
    assign o_evict_sel = state_q == dcache_pkg::S_EVICT;

endmodule

// File: src/dcache_way_array.sv
`timescale 1ns/100ps

module dcache_way_array (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  dcache_pkg::cpu_req_t i_req,
    input  dcache_pkg::off_t     i_beat,
    input  dcache_pkg::word_t    i_wb_dat,
    input  logic                 i_fill_we,
    input  logic                 i_merge_we,
    input  logic                 i_pick_way,
    input  logic                 i_evict_sel,
    input  logic                 i_fill_done,
    output logic                 o_hit,
    output logic                 o_all_dirty,
    output dcache_pkg::word_t    o_rdata,
    output dcache_pkg::addr_t    o_wb_adr,
    output dcache_pkg::word_t    o_wb_dat,
    output dcache_pkg::sel_t     o_wb_sel,
    output logic                 o_wb_burst
);

    localparam int P_DEPTH = 2 ** $bits(dcache_pkg::idx_t);

    dcache_pkg::entry_t ram_out [2];
    dcache_pkg::entry_t ram_in;
    dcache_pkg::entry_t tgt;
    dcache_pkg::entry_t hit_entry;
    dcache_pkg::tag_t   req_tag;
    dcache_pkg::idx_t   req_idx;
    dcache_pkg::off_t   req_off;
    dcache_pkg::tag_t   bus_tag;
    dcache_pkg::line_t  line_q;
    dcache_pkg::line_t  fill_line;
    dcache_pkg::line_t  merge_line;
    dcache_pkg::line_t  rd_line;
    logic [1:0]         way_hit;
    logic [1:0]         way_we;
    logic               victim;
    logic               tx_way;
    logic               last_victim;

    assign req_tag = dcache_pkg::addr_tag(i_req.addr);
    assign req_idx = dcache_pkg::addr_idx(i_req.addr);
    assign req_off = dcache_pkg::addr_off(i_req.addr);

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_ram #(
            .P_DEPTH(P_DEPTH)
        ) ram_i (
            .i_clk  (i_clk),
            .i_rst  (i_rst),
            .i_addr (req_idx),
            .i_we   (way_we[w]),
            .i_data (ram_in),
            .o_data (ram_out[w])
        );

        assign way_hit[w] = ram_out[w].valid && (ram_out[w].tag == req_tag);
        assign way_we[w]  = (i_fill_we | i_merge_we) && (tx_way == w);
    end

    assign o_hit       = |way_hit;
    assign o_all_dirty = ram_out[0].valid & ram_out[0].dirty & ram_out[1].valid & ram_out[1].dirty;
    assign hit_entry   = way_hit[1] ? ram_out[1] : ram_out[0];
    assign tgt         = ram_out[tx_way];

    // Prefer a free way, then a clean one, otherwise alternate
    always_comb begin
        if (!ram_out[0].valid) begin
            victim = 1'b0;
        end else if (!ram_out[1].valid) begin
            victim = 1'b1;
        end else if (!ram_out[0].dirty) begin
            victim = 1'b0;
        end else if (!ram_out[1].dirty) begin
            victim = 1'b1;
        end else begin
            victim = ~last_victim;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tx_way      <= 1'b0;
            last_victim <= 1'b0;
        end else if (i_pick_way) begin
            tx_way <= o_hit ? way_hit[1] : victim;
            if (!o_hit) begin
                last_victim <= victim;
            end
        end
    end

    // The slot of the current beat is rewritten until its ack moves the counter on
    always_ff @(posedge i_clk) begin
        line_q[{i_beat, 4'b0000} +: 16] <= i_wb_dat;
    end

    always_comb begin
        fill_line = line_q;
        fill_line[{i_beat, 4'b0000} +: 16] = i_wb_dat; // Last beat comes straight off the bus
    end

    always_comb begin
        merge_line = tgt.line;
        for (int b = 0; b < 2; b++) begin
            if (i_req.sel[b]) begin
                merge_line[{req_off, 4'b0000} + b * 8 +: 8] = i_req.wdata[b * 8 +: 8];
            end
        end
    end

    always_comb begin
        ram_in.tag   = req_tag;
        ram_in.line  = i_merge_we ? merge_line : fill_line;
        ram_in.dirty = i_merge_we;
        ram_in.valid = 1'b1;
    end

    assign rd_line = i_fill_done ? fill_line : hit_entry.line;
    assign o_rdata = i_req.cache_en ? dcache_pkg::line_word(rd_line, req_off) : i_wb_dat;

    assign bus_tag    = i_evict_sel ? tgt.tag : req_tag;
    assign o_wb_adr   = {bus_tag, req_idx, i_beat};
    assign o_wb_dat   = i_req.cache_en ? dcache_pkg::line_word(tgt.line, i_beat) : i_req.wdata;
    assign o_wb_sel   = i_req.cache_en ? 2'b11 : i_req.sel;
    assign o_wb_burst = i_req.cache_en;

endmodule

// File: src/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
    parameter dcache_pkg::addr_t P_FIRST_PAGE = 24'h000800
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_mem_req,
    input  logic              i_mem_we,
    input  logic              i_mem_cache_en,
    input  dcache_pkg::addr_t i_mem_addr,
    input  dcache_pkg::word_t i_mem_wdata,
    input  dcache_pkg::sel_t  i_mem_sel,
    output dcache_pkg::word_t o_mem_rdata,
    output logic              o_mem_ack,
    output logic              o_mem_exception,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    output logic              o_wb_we,
    output logic              o_wb_burst,
    output dcache_pkg::addr_t o_wb_adr,
    output dcache_pkg::word_t o_wb_dat,
    output dcache_pkg::sel_t  o_wb_sel,
    input  dcache_pkg::word_t i_wb_dat,
    input  logic              i_wb_ack
);

    dcache_pkg::cpu_req_t req;
    dcache_pkg::off_t     cnt_start;
    dcache_pkg::off_t     beat;
    logic                 cnt_load;
    logic                 xfer_end;
    logic                 hit;
    logic                 all_dirty;
    logic                 fill_we;
    logic                 merge_we;
    logic                 pick_way;
    logic                 evict_sel;
    logic                 fill_done;

    assign req = '{
        addr:     i_mem_addr,
        wdata:    i_mem_wdata,
        sel:      i_mem_sel,
        we:       i_mem_we,
        cache_en: i_mem_cache_en
    };

    dcache_ctrl #(
        .P_FIRST_PAGE(P_FIRST_PAGE)
    ) ctrl_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_req           (req),
        .i_mem_req       (i_mem_req),
        .i_hit           (hit),
        .i_all_dirty     (all_dirty),
        .i_xfer_end      (xfer_end),
        .o_mem_ack       (o_mem_ack),
        .o_mem_exception (o_mem_exception),
        .o_wb_cyc        (o_wb_cyc),
        .o_wb_stb        (o_wb_stb),
        .o_wb_we         (o_wb_we),
        .o_cnt_load      (cnt_load),
        .o_cnt_start     (cnt_start),
        .o_fill_we       (fill_we),
        .o_merge_we      (merge_we),
        .o_pick_way      (pick_way),
        .o_evict_sel     (evict_sel),
        .o_fill_done     (fill_done)
    );

    dcache_beat_cnt beat_cnt_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_load     (cnt_load),
        .i_start    (cnt_start),
        .i_single   (~i_mem_cache_en),
        .i_active   (o_wb_cyc & o_wb_stb),
        .i_wb_ack   (i_wb_ack),
        .o_beat     (beat),
        .o_xfer_end (xfer_end)
    );

    dcache_way_array way_array_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req       (req),
        .i_beat      (beat),
        .i_wb_dat    (i_wb_dat),
        .i_fill_we   (fill_we),
        .i_merge_we  (merge_we),
        .i_pick_way  (pick_way),
        .i_evict_sel (evict_sel),
        .i_fill_done (fill_done),
        .o_hit       (hit),
        .o_all_dirty (all_dirty),
        .o_rdata     (o_mem_rdata),
        .o_wb_adr    (o_wb_adr),
        .o_wb_dat    (o_wb_dat),
        .o_wb_sel    (o_wb_sel),
        .o_wb_burst  (o_wb_burst)
    );

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_cyc,
    input  logic              i_stb,
    input  logic              i_we,
    input  dcache_pkg::addr_t i_adr,
    input  dcache_pkg::word_t i_dat,
    input  dcache_pkg::sel_t  i_sel,
    output dcache_pkg::word_t o_dat,
    output logic              o_ack
);

    dcache_pkg::word_t mem [4096];
    integer            seed = 32'hd8fafc6b;
    int unsigned       wait_cnt;
    logic              pending;
    logic [11:0]       idx;

    assign idx = i_adr[11:0]; // Storage wraps every 4096 words

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 16'(i) ^ 16'h5A5A;
        end
    end

    // Each beat waits 0 to 2 extra cycles, then ack is high for exactly one cycle
    always @(posedge i_clk) begin
        if (i_rst) begin
            o_ack    <= 1'b0;
            o_dat    <= '0;
            pending  <= 1'b0;
            wait_cnt <= 0;
        end else begin
            o_ack <= 1'b0;
            if (i_cyc && i_stb && o_ack) begin
                if (i_we && i_sel[0]) begin
                    mem[idx][7:0] <= i_dat[7:0];
                end
                if (i_we && i_sel[1]) begin
                    mem[idx][15:8] <= i_dat[15:8];
                end
            end else if (i_cyc && i_stb) begin
                if (!pending) begin
                    pending  <= 1'b1;
                    wait_cnt <= $unsigned($random(seed)) % 3;
                end else if (wait_cnt == 0) begin
                    pending <= 1'b0;
                    o_ack   <= 1'b1;
                    o_dat   <= mem[idx];
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

    function automatic dcache_pkg::word_t peek(dcache_pkg::addr_t a);
        return mem[a[11:0]];
    endfunction

endmodule

// File: bench/dcache_chk.sv
`timescale 1ns/100ps

module dcache_chk (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_mem_ack,
    input logic i_mem_exception
);

    int fail_count = 0;

    stb_needs_cyc: assert property (@(posedge i_clk) disable iff (i_rst) i_wb_stb |-> i_wb_cyc)
        else begin
            fail_count++;
            $error("stb is high while cyc is low");
        end

    // An access ends either with an acknowledge or with an exception
    ack_or_exception: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_mem_ack && i_mem_exception))
        else begin
            fail_count++;
            $error("acknowledge and exception are high together");
        end

    cyc_low_after_reset: assert property (@(posedge i_clk) $fell(i_rst) |-> !i_wb_cyc)
        else begin
            fail_count++;
            $error("cyc is high in the first cycle after reset");
        end

endmodule

// File: bench/tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache;

    localparam int TIMEOUT = 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              mem_req;
    logic              mem_we;
    logic              mem_cache_en;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::word_t mem_wdata;
    dcache_pkg::sel_t  mem_sel;
    dcache_pkg::word_t mem_rdata;
    logic              mem_ack;
    logic              mem_exc;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic              wb_burst;
    dcache_pkg::addr_t wb_adr;
    dcache_pkg::word_t wb_dat_out;
    dcache_pkg::sel_t  wb_sel;
    dcache_pkg::word_t wb_dat_in;
    logic              wb_ack;

    dcache_pkg::word_t mirror [4096]; // Values that reads are expected to return
    dcache_pkg::word_t last_rdata;
    logic              last_ack;
    logic              last_exc;
    logic              cyc_seen;
    logic              burst_seen;
    int                beats;
    int                cycles;

    always #50 clk = ~clk;

    dcache_top dut_i (
        .i_clk(clk), .i_rst(rst), .i_mem_req(mem_req), .i_mem_we(mem_we),
        .i_mem_cache_en(mem_cache_en), .i_mem_addr(mem_addr), .i_mem_wdata(mem_wdata),
        .i_mem_sel(mem_sel), .o_mem_rdata(mem_rdata), .o_mem_ack(mem_ack),
        .o_mem_exception(mem_exc), .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
        .o_wb_burst(wb_burst), .o_wb_adr(wb_adr), .o_wb_dat(wb_dat_out), .o_wb_sel(wb_sel),
        .i_wb_dat(wb_dat_in), .i_wb_ack(wb_ack)
    );

    wb_mem_model mem_i (
        .i_clk(clk), .i_rst(rst), .i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we),
        .i_adr(wb_adr), .i_dat(wb_dat_out), .i_sel(wb_sel), .o_dat(wb_dat_in), .o_ack(wb_ack)
    );

    bind dcache_top dcache_chk chk_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb),
        .i_mem_ack(o_mem_ack), .i_mem_exception(o_mem_exception)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Starts and ends on a falling edge, bus beats are counted along the way
    task automatic do_access(input dcache_pkg::addr_t addr, input logic we,
                             input dcache_pkg::word_t wdata, input dcache_pkg::sel_t sel,
                             input logic cache_en);
        logic done;
        done       = 1'b0;
        cycles     = 0;
        beats      = 0;
        cyc_seen   = 1'b0;
        burst_seen = 1'b0;
        mem_req      = 1'b1;
        mem_we       = we;
        mem_addr     = addr;
        mem_wdata    = wdata;
        mem_sel      = sel;
        mem_cache_en = cache_en;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (wb_cyc) begin
                cyc_seen = 1'b1;
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                beats++;
                burst_seen = burst_seen | wb_burst;
            end
            if (mem_ack || mem_exc) begin
                done       = 1'b1;
                last_ack   = mem_ack;
                last_exc   = mem_exc;
                last_rdata = mem_rdata;
            end else if (cycles >= TIMEOUT) begin
                $display("timeout: no acknowledge or exception for address 0x%06h", addr);
                $display(">>> FAIL");
                $fatal(1, "access timed out");
            end
        end
        mem_req = 1'b0;
        mem_we  = 1'b0;
        @(negedge clk);
        if (mem_ack || mem_exc) begin
            $display("acknowledge or exception stayed high for more than one cycle");
            $display(">>> FAIL");
            $fatal(1, "pulse too long");
        end
    endtask

    task automatic read_expect(input string name, input dcache_pkg::addr_t addr,
                               input logic cache_en);
        do_access(addr, 1'b0, '0, 2'b11, cache_en);
        check({name, " ack"}, 1, last_ack);
        check({name, " data"}, mirror[addr[11:0]], last_rdata);
    endtask

    task automatic write_word(input string name, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t data, input dcache_pkg::sel_t sel,
                              input logic cache_en);
        do_access(addr, 1'b1, data, sel, cache_en);
        check({name, " ack"}, 1, last_ack);
        if (sel[0]) begin
            mirror[addr[11:0]][7:0] = data[7:0];
        end
        if (sel[1]) begin
            mirror[addr[11:0]][15:8] = data[15:8];
        end
    endtask

    task automatic check_reset_state();
        check("reset_state cyc", 0, wb_cyc);
        check("reset_state ack", 0, mem_ack);
        check("reset_state exception", 0, mem_exc);
    endtask

    task automatic read_miss_then_hit();
        read_expect("read_miss_hit miss", 24'h000840, 1'b1);
        check("read_miss_hit miss beats", 4, beats);
        check("read_miss_hit miss burst", 1, burst_seen);
        read_expect("read_miss_hit hit", 24'h000842, 1'b1);
        check("read_miss_hit hit bus", 0, cyc_seen);
        check("read_miss_hit hit latency", 1, cycles);
    endtask

    task automatic write_merge();
        write_word("write_merge word", 24'h000861, 16'h1234, 2'b11, 1'b1);
        write_word("write_merge low byte", 24'h000862, 16'hABCD, 2'b01, 1'b1);
        write_word("write_merge high byte", 24'h000863, 16'hEF01, 2'b10, 1'b1);
        check("write_merge hit latency", 2, cycles); // Lookup, then merge
        read_expect("write_merge reread 0", 24'h000860, 1'b1);
        read_expect("write_merge reread 1", 24'h000861, 1'b1);
        read_expect("write_merge reread 2", 24'h000862, 1'b1);
        read_expect("write_merge reread 3", 24'h000863, 1'b1);
    endtask

    // Set 5 fills way 0, then way 1, so the third tag must evict way 0 by alternation
    task automatic dirty_eviction();
        write_word("dirty_eviction a", 24'h000814, 16'h1111, 2'b11, 1'b1);
        write_word("dirty_eviction b", 24'h000914, 16'h2222, 2'b11, 1'b1);
        write_word("dirty_eviction c", 24'h000A14, 16'h3333, 2'b11, 1'b1);
        check("dirty_eviction beats", 8, beats);
        check("dirty_eviction write-back", 16'h1111, mem_i.peek(24'h000814));
        read_expect("dirty_eviction reread a", 24'h000814, 1'b1);
        read_expect("dirty_eviction reread b", 24'h000914, 1'b1);
        read_expect("dirty_eviction reread c", 24'h000A14, 1'b1);
    endtask

    // Only the low lane is written, so the bus select reaches the memory
    task automatic uncached_access();
        write_word("uncached write", 24'h000B20, 16'hC3C3, 2'b01, 1'b0);
        check("uncached write beats", 1, beats);
        check("uncached write burst", 0, burst_seen);
        check("uncached write model", mirror[12'hB20], mem_i.peek(24'h000B20));
        read_expect("uncached read", 24'h000B27, 1'b0);
        check("uncached read beats", 1, beats);
        check("uncached read burst", 0, burst_seen);
    endtask

    task automatic illegal_address();
        do_access(24'h0007FE, 1'b0, '0, 2'b11, 1'b1);
        check("illegal_address exception", 1, last_exc);
        check("illegal_address ack", 0, last_ack);
        check("illegal_address bus", 0, cyc_seen);
        check("illegal_address latency", 1, cycles);
    endtask

    initial begin
        rst          = 1'b1;
        mem_req      = 1'b0;
        mem_we       = 1'b0;
        mem_cache_en = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_sel      = '0;
        for (int i = 0; i < 4096; i++) begin
            mirror[i] = 16'(i) ^ 16'h5A5A;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        read_miss_then_hit();
        write_merge();
        dirty_eviction();
        uncached_access();
        illegal_address();
        if (dut_i.chk_i.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("bus checker reported %0d assertion failures", dut_i.chk_i.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failures in the bus checker");
        end
    end

endmodule

// File: dcache_top.f
src/dcache_pkg.sv
src/dcache_ram.sv
src/dcache_beat_cnt.sv
src/dcache_ctrl.sv
src/dcache_way_array.sv
src/dcache_top.sv
bench/wb_mem_model.sv
bench/dcache_chk.sv
bench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_ram.sv
  - src/dcache_beat_cnt.sv
  - src/dcache_ctrl.sv
  - src/dcache_way_array.sv
  - src/dcache_top.sv
  - target: test
    files:
      - bench/wb_mem_model.sv
      - bench/dcache_chk.sv
      - bench/tb_dcache.sv
